// ==== ddr3_decay_test_top.f ====
ddr3_timing_pkg.sv
ddr3_dfi_pkg.sv
ddr3_init_seq.sv
ddr3_decay_seq.sv
ddr3_dfi_merge.sv
ddr3_decay_test_top.sv
ddr3_decay_test_asserts.sv
tb_ddr3_decay_test_top.sv

// ==== tb_ddr3_decay_test_top.sv ====
// Testbench for the DDR3 decay test controller
// Runs a clean and a corrupted retention test against a one-word DFI memory model
`timescale 1ns/100ps
`default_nettype none

module tb_ddr3_decay_test_top;

    logic                   clk_phy_sys;
    logic                   sys_rst_fsm_phy;
    logic                   start_i;
    logic [31:0]            dfi_rddata_i;
    logic                   dfi_rddata_valid_i;
    ddr3_dfi_pkg::dfi_cmd_t dfi_cmd_o;
    logic                   busy_led_o;
    logic                   pass_led_o;
    logic                   fail_led_o;
    logic                   init_led_o;

    logic [31:0] mem_word = 32'd0;
    logic [31:0] corrupt_mask;
    logic        corrupt_armed = 1'b0;
    int          rd_countdown = 0;
    integer      seed = 32'h3020592f;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          fails_seen = 0;

    ddr3_decay_test_top uut (
        .clk_phy_sys        (clk_phy_sys),
        .sys_rst_fsm_phy    (sys_rst_fsm_phy),
        .start_i            (start_i),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .dfi_cmd_o          (dfi_cmd_o),
        .busy_led_o         (busy_led_o),
        .pass_led_o         (pass_led_o),
        .fail_led_o         (fail_led_o),
        .init_led_o         (init_led_o)
    );

    initial begin
        clk_phy_sys = 1'b0;
        forever #4 clk_phy_sys = ~clk_phy_sys;
    end

    // Memory model, one word, read data 6 cycles after the read command
    always @(negedge clk_phy_sys) begin
        dfi_rddata_valid_i = 1'b0;
        if (!dfi_cmd_o.cs_n && dfi_cmd_o.wrdata_en) mem_word = dfi_cmd_o.wrdata;
        if (!dfi_cmd_o.cs_n && dfi_cmd_o.rddata_en) begin
            rd_countdown = 6;
        end else if (rd_countdown > 0) begin
            rd_countdown = rd_countdown - 1;
            if (rd_countdown == 0) begin
                corrupt_mask = $random(seed);
                if (corrupt_mask == 32'd0) corrupt_mask = 32'd1;
                dfi_rddata_i       = corrupt_armed ? (mem_word ^ corrupt_mask) : mem_word;
                dfi_rddata_valid_i = 1'b1;
            end
        end
    end

    task automatic pulse_start;
        @(negedge clk_phy_sys);
        start_i = 1'b1;
        repeat (3) @(negedge clk_phy_sys);
        start_i = 1'b0;
    endtask

    task automatic wait_busy_fall;
        while (!busy_led_o) @(negedge clk_phy_sys);
        while (busy_led_o) @(negedge clk_phy_sys);
        repeat (4) @(negedge clk_phy_sys);
    endtask

    // Assertion failures since the previous test decide this one
    task automatic finish_test(input string name);
        int new_fails;
        new_fails  = uut.u_asserts.fail_count - fails_seen;
        fails_seen = uut.u_asserts.fail_count;
        if (new_fails == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d assertion failures", name, new_fails);
        end
    endtask

    initial begin
        sys_rst_fsm_phy    = 1'b1;
        start_i            = 1'b0;
        dfi_rddata_i       = 32'd0;
        dfi_rddata_valid_i = 1'b0;
        repeat (3) @(posedge clk_phy_sys);
        @(negedge clk_phy_sys);
        sys_rst_fsm_phy = 1'b0;

        repeat (20) @(negedge clk_phy_sys);
        finish_test("reset_idle");

        pulse_start();
        while (!init_led_o) @(negedge clk_phy_sys);
        finish_test("power_up");

        while (!dfi_cmd_o.rddata_en) @(negedge clk_phy_sys);
        finish_test("write_and_decay");

        wait_busy_fall();
        finish_test("clean_verdict");

        pulse_start();   // Done back to idle
        while (!dfi_cmd_o.cs_n) @(negedge clk_phy_sys);
        repeat (20) @(negedge clk_phy_sys);
        finish_test("return_idle");

        corrupt_armed = 1'b1;
        pulse_start();
        wait_busy_fall();
        finish_test("corrupted_verdict");

        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 uut.u_asserts.fail_count);
        if (tests_failed == 0 && uut.u_asserts.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Twice the waits of one run, for two runs, plus margin
    initial begin
        longint run_cycles;
        run_cycles = ddr3_timing_pkg::T_RESET + ddr3_timing_pkg::T_STABLE
                   + 2 * ddr3_timing_pkg::T_INIT_WAIT + 4 * ddr3_timing_pkg::T_MRD
                   + ddr3_timing_pkg::T_ZQINIT + 2 * ddr3_timing_pkg::T_RCD
                   + ddr3_timing_pkg::T_WR + ddr3_timing_pkg::T_RP
                   + ddr3_timing_pkg::T_RD_TIMEOUT + ddr3_timing_pkg::T_DECAY;
        #((2 * run_cycles * 2 + 2000) * 8);
        $display("watchdog expired before the last test finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule : tb_ddr3_decay_test_top

`default_nettype wire

// ==== ddr3_decay_test_asserts.sv ====
// Bound checks for the DDR3 decay test controller
// Watches the DFI port for power-up order, write contents, decay quiet time and the verdict
`timescale 1ns/100ps
`default_nettype none

module ddr3_decay_test_asserts (
    input logic                   clk_phy_sys,
    input logic                   sys_rst_fsm_phy,
    input logic                   start_i,
    input logic [31:0]            dfi_rddata_i,
    input logic                   dfi_rddata_valid_i,
    input ddr3_dfi_pkg::dfi_cmd_t dfi_cmd_o,
    input logic                   busy_led_o,
    input logic                   pass_led_o,
    input logic                   fail_led_o,
    input logic                   init_led_o
);

    int fail_count = 0;   // Read by the testbench

    ddr3_dfi_pkg::dfi_cmd_t prev_cmd_q;

    logic [3:0]  leds;
    logic [17:0] wr_ctrl;   // wrdata_en, mask, bank, column
    logic        is_cmd;
    logic        is_mrs;
    logic        is_zq;
    logic        is_write;
    logic        is_pre;
    logic        is_read;
    logic        new_mrs;
    logic        new_zq;
    logic        seen_start_q;
    logic        zq_seen_q;
    logic        wr_seen_q;   // Write issued since the last idle
    logic        wr_pending_q;
    logic        pre_seen_q;
    logic        exp_match_q;
    logic [2:0]  mrs_idx_q;
    logic [2:0]  exp_bank;
    logic [14:0] exp_val;
    int unsigned quiet_q;    // NOP cycles since the precharge

    assign leds    = {busy_led_o, pass_led_o, fail_led_o, init_led_o};
    assign wr_ctrl = {dfi_cmd_o.wrdata_en, dfi_cmd_o.wrdata_mask, dfi_cmd_o.bank,
                      dfi_cmd_o.address[9:0]};

    // Selected and not a NOP
    assign is_cmd   = !dfi_cmd_o.cs_n && !(dfi_cmd_o.ras_n && dfi_cmd_o.cas_n && dfi_cmd_o.we_n);
    assign is_mrs   = is_cmd && !dfi_cmd_o.ras_n && !dfi_cmd_o.cas_n && !dfi_cmd_o.we_n;
    assign is_zq    = is_cmd && dfi_cmd_o.ras_n && dfi_cmd_o.cas_n && !dfi_cmd_o.we_n;
    assign is_write = is_cmd && dfi_cmd_o.ras_n && !dfi_cmd_o.cas_n && !dfi_cmd_o.we_n;
    assign is_pre   = is_cmd && !dfi_cmd_o.ras_n && dfi_cmd_o.cas_n && !dfi_cmd_o.we_n;
    assign is_read  = is_cmd && dfi_cmd_o.ras_n && !dfi_cmd_o.cas_n && dfi_cmd_o.we_n;
    assign new_mrs  = is_mrs && (dfi_cmd_o != prev_cmd_q);
    assign new_zq   = is_zq && (dfi_cmd_o != prev_cmd_q);

    // DDR3 order is MR2, MR3, MR1, MR0
    always_comb begin
        case (mrs_idx_q)
            3'd0: {exp_bank, exp_val} = {ddr3_dfi_pkg::BANK_MR2, ddr3_dfi_pkg::MR2_VAL};
            3'd1: {exp_bank, exp_val} = {ddr3_dfi_pkg::BANK_MR3, ddr3_dfi_pkg::MR3_VAL};
            3'd2: {exp_bank, exp_val} = {ddr3_dfi_pkg::BANK_MR1, ddr3_dfi_pkg::MR1_VAL};
            3'd3: {exp_bank, exp_val} = {ddr3_dfi_pkg::BANK_MR0, ddr3_dfi_pkg::MR0_VAL};
            default: {exp_bank, exp_val} = {3'b111, 15'h7fff};
        endcase
    end

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            prev_cmd_q   <= '0;
            seen_start_q <= 1'b0;
            mrs_idx_q    <= '0;
            zq_seen_q    <= 1'b0;
            wr_seen_q    <= 1'b0;
            wr_pending_q <= 1'b0;
            pre_seen_q   <= 1'b0;
            quiet_q      <= 0;
            exp_match_q  <= 1'b0;
        end else begin
            prev_cmd_q <= dfi_cmd_o;
            if (start_i) seen_start_q <= 1'b1;
            if (dfi_cmd_o.cs_n) begin
                mrs_idx_q <= '0;   // Back in idle so the next run starts over
                zq_seen_q <= 1'b0;
                wr_seen_q <= 1'b0;
            end else if (new_mrs) begin
                mrs_idx_q <= mrs_idx_q + 1'b1;
            end
            if (new_zq) zq_seen_q <= 1'b1;
            if (is_write) begin
                wr_pending_q <= 1'b1;
                wr_seen_q    <= 1'b1;
            end else if (is_cmd) begin
                wr_pending_q <= 1'b0;
            end
            if (is_pre) begin
                pre_seen_q <= 1'b1;
                quiet_q    <= 0;
            end else if (is_cmd) begin
                pre_seen_q <= 1'b0;
            end else if (pre_seen_q) begin
                quiet_q <= quiet_q + 1;
            end
            if (is_read) begin
                exp_match_q <= 1'b0;   // Stays 0 if no data comes back
            end else if (dfi_rddata_valid_i) begin
                exp_match_q <= (dfi_rddata_i == ddr3_timing_pkg::TEST_PATTERN);
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        !seen_start_q |-> dfi_cmd_o.cs_n && !dfi_cmd_o.cke && leds == 4'h0)
        else begin
            $error("[ERROR] dfi_cmd_o.cs_n,cke 0x%0h,0x%0h leds 0x%0h, expected 0x1,0x0 0x0",
                   $sampled(dfi_cmd_o.cs_n), $sampled(dfi_cmd_o.cke), $sampled(leds));
            fail_count++;
        end

    a_idle_dark: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        dfi_cmd_o.cs_n |-> !dfi_cmd_o.cke && leds == 4'h0)
        else begin
            $error("[ERROR] idle dfi_cmd_o.cke 0x%0h leds 0x%0h, expected 0x0 0x0",
                   $sampled(dfi_cmd_o.cke), $sampled(leds));
            fail_count++;
        end

    a_mrs_order: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        new_mrs |-> mrs_idx_q < 3'd4 && dfi_cmd_o.bank == exp_bank &&
                    dfi_cmd_o.address == exp_val)
        else begin
            $error("[ERROR] MRS %0d dfi_cmd_o.bank,address 0x%0h,0x%0h, expected 0x%0h,0x%0h",
                   $sampled(mrs_idx_q), $sampled(dfi_cmd_o.bank),
                   $sampled(dfi_cmd_o.address), $sampled(exp_bank), $sampled(exp_val));
            fail_count++;
        end

    a_zqcl_last: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        new_zq |-> mrs_idx_q == 3'd4 && dfi_cmd_o.address[ddr3_dfi_pkg::A10_BIT])
        else begin
            $error("[ERROR] ZQCL after 0x%0h MRS, dfi_cmd_o.address 0x%0h, expected 0x4 0x400",
                   $sampled(mrs_idx_q), $sampled(dfi_cmd_o.address));
            fail_count++;
        end

    a_init_after_zq: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        $rose(init_led_o) |-> zq_seen_q)
        else begin
            $error("init_led_o rose before any ZQCL command in this run");
            fail_count++;
        end

    a_write_fields: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        is_write |-> dfi_cmd_o.wrdata == ddr3_timing_pkg::TEST_PATTERN &&
                     wr_ctrl == {1'b1, 4'h0, ddr3_timing_pkg::TEST_BANK,
                                 ddr3_timing_pkg::TEST_COL})
        else begin
            $error("[ERROR] dfi_cmd_o.wrdata 0x%h en,mask,bank,col 0x%h, expected 0x%h 0x%h",
                   $sampled(dfi_cmd_o.wrdata), $sampled(wr_ctrl),
                   ddr3_timing_pkg::TEST_PATTERN,
                   {1'b1, 4'h0, ddr3_timing_pkg::TEST_BANK, ddr3_timing_pkg::TEST_COL});
            fail_count++;
        end

    a_read_after_write: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        is_read |-> wr_seen_q)
        else begin
            $error("read command issued before any write command in this run");
            fail_count++;
        end

    a_pre_after_write: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        is_cmd && wr_pending_q |-> is_pre && dfi_cmd_o.address[ddr3_dfi_pkg::A10_BIT])
        else begin
            $error("[ERROR] after write dfi_cmd_o.ras_n,cas_n,we_n 0x%0h address 0x%0h, %s",
                   $sampled({dfi_cmd_o.ras_n, dfi_cmd_o.cas_n, dfi_cmd_o.we_n}),
                   $sampled(dfi_cmd_o.address), "expected 0x2 0x400");
            fail_count++;
        end

    a_decay_quiet: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        is_cmd && pre_seen_q |-> quiet_q >= ddr3_timing_pkg::T_DECAY)
        else begin
            $error("[ERROR] dfi_cmd_o command after 0x%0h NOP cycles, expected at least 0x%0h",
                   $sampled(quiet_q), ddr3_timing_pkg::T_DECAY);
            fail_count++;
        end

    a_verdict: assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        $fell(busy_led_o) |-> pass_led_o == exp_match_q && fail_led_o == !exp_match_q)
        else begin
            $error("[ERROR] pass_led_o,fail_led_o 0x%0h,0x%0h, expected 0x%0h,0x%0h",
                   $sampled(pass_led_o), $sampled(fail_led_o),
                   $sampled(exp_match_q), !$sampled(exp_match_q));
            fail_count++;
        end

endmodule : ddr3_decay_test_asserts

bind ddr3_decay_test_top ddr3_decay_test_asserts u_asserts (
    .clk_phy_sys        (clk_phy_sys),
    .sys_rst_fsm_phy    (sys_rst_fsm_phy),
    .start_i            (start_i),
    .dfi_rddata_i       (dfi_rddata_i),
    .dfi_rddata_valid_i (dfi_rddata_valid_i),
    .dfi_cmd_o          (dfi_cmd_o),
    .busy_led_o         (busy_led_o),
    .pass_led_o         (pass_led_o),
    .fail_led_o         (fail_led_o),
    .init_led_o         (init_led_o)
);

`default_nettype wire

// ==== ddr3_decay_test_top.sv ====
// DDR3 decay test controller
// Power-up and test sequencers side by side, joined by the DFI output stage
`timescale 1ns/100ps
`default_nettype none

module ddr3_decay_test_top (
    input  logic                    clk_phy_sys,
    input  logic                    sys_rst_fsm_phy,
    input  logic                    start_i,
    input  logic [31:0]             dfi_rddata_i,
    input  logic                    dfi_rddata_valid_i,
    output ddr3_dfi_pkg::dfi_cmd_t  dfi_cmd_o,
    output logic                    busy_led_o,
    output logic                    pass_led_o,
    output logic                    fail_led_o,
    output logic                    init_led_o
);

    ddr3_dfi_pkg::dfi_cmd_t    init_cmd;
    ddr3_dfi_pkg::dfi_cmd_t    test_cmd;
    ddr3_dfi_pkg::rd_result_t  result;
    logic                      init_done;
    logic                      test_go;   // Single-cycle kick into the test sequence
    logic                      active;
    logic                      test_done;

    ddr3_init_seq u_init_seq (
        .clk_phy_sys     (clk_phy_sys),
        .sys_rst_fsm_phy (sys_rst_fsm_phy),
        .start_i         (start_i),
        .test_done_i     (test_done),
        .init_cmd_o      (init_cmd),
        .init_done_o     (init_done),
        .test_go_o       (test_go),
        .active_o        (active)
    );

    ddr3_decay_seq u_decay_seq (
        .clk_phy_sys        (clk_phy_sys),
        .sys_rst_fsm_phy    (sys_rst_fsm_phy),
        .test_go_i          (test_go),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .test_cmd_o         (test_cmd),
        .test_done_o        (test_done),
        .result_o           (result)
    );

    ddr3_dfi_merge u_dfi_merge (
        .clk_phy_sys     (clk_phy_sys),
        .sys_rst_fsm_phy (sys_rst_fsm_phy),
        .init_cmd_i      (init_cmd),
        .test_cmd_i      (test_cmd),
        .init_done_i     (init_done),
        .active_i        (active),
        .result_i        (result),
        .dfi_cmd_o       (dfi_cmd_o),
        .busy_led_o      (busy_led_o),
        .pass_led_o      (pass_led_o),
        .fail_led_o      (fail_led_o),
        .init_led_o      (init_led_o)
    );

endmodule : ddr3_decay_test_top

`default_nettype wire

// ==== ddr3_dfi_merge.sv ====
// DFI output stage
// Picks the power-up or test command, registers the bus and derives the status LEDs
`timescale 1ns/100ps
`default_nettype none

module ddr3_dfi_merge (
    input  logic                      clk_phy_sys,
    input  logic                      sys_rst_fsm_phy,
    input  ddr3_dfi_pkg::dfi_cmd_t    init_cmd_i,
    input  ddr3_dfi_pkg::dfi_cmd_t    test_cmd_i,
    input  logic                      init_done_i,
    input  logic                      active_i,
    input  ddr3_dfi_pkg::rd_result_t  result_i,
    output ddr3_dfi_pkg::dfi_cmd_t    dfi_cmd_o,
    output logic                      busy_led_o,
    output logic                      pass_led_o,
    output logic                      fail_led_o,
    output logic                      init_led_o
);

    ddr3_dfi_pkg::dfi_cmd_t dfi_cmd_q;

    logic busy_q;
    logic pass_q;
    logic fail_q;
    logic init_q;
    logic verdict;   // A finished run has a result to show

    assign verdict = result_i.valid && init_done_i && !active_i;

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            dfi_cmd_q <= ddr3_dfi_pkg::DFI_IDLE;
            busy_q    <= 1'b0;
            pass_q    <= 1'b0;
            fail_q    <= 1'b0;
            init_q    <= 1'b0;
        end else begin
            // Test sequencer owns the bus once power-up is complete
            dfi_cmd_q <= init_done_i ? test_cmd_i : init_cmd_i;
            busy_q    <= active_i;
            init_q    <= init_done_i;
            pass_q    <= verdict && result_i.match;
            fail_q    <= verdict && !result_i.match;
        end
    end

    assign dfi_cmd_o  = dfi_cmd_q;
    assign busy_led_o = busy_q;
    assign pass_led_o = pass_q;
    assign fail_led_o = fail_q;
    assign init_led_o = init_q;

endmodule : ddr3_dfi_merge

`default_nettype wire

// ==== ddr3_decay_seq.sv ====
// DDR3 decay test sequencer
// Writes the pattern, waits out the decay period without refresh, reads back and compares
`timescale 1ns/100ps
`default_nettype none

module ddr3_decay_seq (
    input  logic                      clk_phy_sys,
    input  logic                      sys_rst_fsm_phy,
    input  logic                      test_go_i,
    input  logic [31:0]               dfi_rddata_i,
    input  logic                      dfi_rddata_valid_i,
    output ddr3_dfi_pkg::dfi_cmd_t    test_cmd_o,
    output logic                      test_done_o,
    output ddr3_dfi_pkg::rd_result_t  result_o
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_WR_ACT,
        S_WR_ACT_WAIT,
        S_WR_CMD,
        S_WR_WAIT,
        S_PRE,
        S_PRE_WAIT,
        S_DECAY,
        S_RD_ACT,
        S_RD_ACT_WAIT,
        S_RD_CMD,
        S_RD_WAIT
    } test_state_t;

    test_state_t state_q, state_d;

    logic [ddr3_timing_pkg::TIMER_W-1:0] timer_q;
    logic        rd_end;        // Read wait finishes this cycle
    logic        test_done_q;
    logic        rd_valid_q;
    logic        rd_match_q;
    logic [31:0] rd_data_q;

    always_comb begin
        state_d    = state_q;
        test_cmd_o = ddr3_dfi_pkg::DFI_NOP;
        case (state_q)
            S_IDLE: begin
                if (test_go_i) state_d = S_WR_ACT;
            end
            S_WR_ACT, S_RD_ACT: begin
                test_cmd_o.ras_n   = 1'b0;
                test_cmd_o.bank    = ddr3_timing_pkg::TEST_BANK;
                test_cmd_o.address = {1'b0, ddr3_timing_pkg::TEST_ROW};
                state_d = (state_q == S_WR_ACT) ? S_WR_ACT_WAIT : S_RD_ACT_WAIT;
            end
            S_WR_ACT_WAIT: begin
                if (timer_q >= ddr3_timing_pkg::T_RCD) state_d = S_WR_CMD;
            end
            S_WR_CMD: begin
                test_cmd_o.cas_n       = 1'b0;
                test_cmd_o.we_n        = 1'b0;
                test_cmd_o.bank        = ddr3_timing_pkg::TEST_BANK;
                test_cmd_o.address     = {5'd0, ddr3_timing_pkg::TEST_COL};
                test_cmd_o.wrdata      = ddr3_timing_pkg::TEST_PATTERN;
                test_cmd_o.wrdata_en   = 1'b1;
                test_cmd_o.wrdata_mask = 4'h0;  // All bytes written
                test_cmd_o.odt         = 1'b1;
                state_d = S_WR_WAIT;
            end
            S_WR_WAIT: begin
                if (timer_q >= ddr3_timing_pkg::T_WR) state_d = S_PRE;
            end
            S_PRE: begin
                test_cmd_o.ras_n                          = 1'b0;
                test_cmd_o.we_n                           = 1'b0;
                test_cmd_o.address[ddr3_dfi_pkg::A10_BIT] = 1'b1;  // All banks
                state_d = S_PRE_WAIT;
            end
            S_PRE_WAIT: begin
                if (timer_q >= ddr3_timing_pkg::T_RP) state_d = S_DECAY;
            end
            S_DECAY: begin
                // Cells left alone, no refresh
                if (timer_q >= ddr3_timing_pkg::T_DECAY) state_d = S_RD_ACT;
            end
            S_RD_ACT_WAIT: begin
                if (timer_q >= ddr3_timing_pkg::T_RCD) state_d = S_RD_CMD;
            end
            S_RD_CMD: begin
                test_cmd_o.cas_n     = 1'b0;
                test_cmd_o.bank      = ddr3_timing_pkg::TEST_BANK;
                test_cmd_o.address   = {5'd0, ddr3_timing_pkg::TEST_COL};
                test_cmd_o.rddata_en = 1'b1;
                state_d = S_RD_WAIT;
            end
            S_RD_WAIT: begin
                if (rd_end) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Data valid, or timeout with nothing returned
    assign rd_end = (state_q == S_RD_WAIT) &&
                    (dfi_rddata_valid_i || timer_q >= ddr3_timing_pkg::T_RD_TIMEOUT);

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            state_q     <= S_IDLE;
            timer_q     <= '0;
            test_done_q <= 1'b0;
            rd_valid_q  <= 1'b0;
            rd_match_q  <= 1'b0;
        end else begin
            state_q     <= state_d;
            timer_q     <= (state_d != state_q) ? '0 : timer_q + 1'b1;
            test_done_q <= rd_end;
            if (test_go_i) begin
                rd_valid_q <= 1'b0;
                rd_match_q <= 1'b0;
            end else if (rd_end) begin
                rd_valid_q <= 1'b1;
                rd_match_q <= dfi_rddata_valid_i &&
                              (dfi_rddata_i == ddr3_timing_pkg::TEST_PATTERN);
            end
        end
    end

    // Captured word, zero on timeout
    always_ff @(posedge clk_phy_sys) begin
        if (rd_end) begin
            rd_data_q <= dfi_rddata_valid_i ? dfi_rddata_i : 32'd0;
        end
    end

    assign test_done_o = test_done_q;
    assign result_o    = '{valid: rd_valid_q, match: rd_match_q, data: rd_data_q};

endmodule : ddr3_decay_seq

`default_nettype wire

// ==== ddr3_init_seq.sv ====
// DDR3 power-up sequencer
// Detects the start edge, runs reset, CKE, MRS and ZQCL steps and hands over to the test
`timescale 1ns/100ps
`default_nettype none

module ddr3_init_seq (
    input  logic                    clk_phy_sys,
    input  logic                    sys_rst_fsm_phy,
    input  logic                    start_i,
    input  logic                    test_done_i,
    output ddr3_dfi_pkg::dfi_cmd_t  init_cmd_o,
    output logic                    init_done_o,
    output logic                    test_go_o,
    output logic                    active_o
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_RESET,
        S_CKE_LOW,
        S_STABLE,
        S_MRS2,
        S_MRS3,
        S_MRS1,
        S_MRS0,
        S_ZQCL,
        S_SETTLE,
        S_HANDOFF,
        S_DONE
    } init_state_t;

    init_state_t state_q, state_d;

    logic [ddr3_timing_pkg::TIMER_W-1:0] timer_q;
    logic [2:0] start_sync_q;   // Two sync stages plus edge history
    logic       start_edge_q;
    logic       init_done_q;
    logic       test_go_q;
    logic       active_q;
    logic       settle_end;

    // Mode register set with bank select and the register word on the address
    function automatic ddr3_dfi_pkg::dfi_cmd_t mrs_cmd(input logic [2:0]  bank,
                                                       input logic [14:0] value);
        ddr3_dfi_pkg::dfi_cmd_t cmd;
        cmd         = ddr3_dfi_pkg::DFI_NOP;
        cmd.ras_n   = 1'b0;
        cmd.cas_n   = 1'b0;
        cmd.we_n    = 1'b0;
        cmd.bank    = bank;
        cmd.address = value;
        return cmd;
    endfunction

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            start_sync_q <= 3'b000;
            start_edge_q <= 1'b0;
        end else begin
            start_sync_q <= {start_sync_q[1:0], start_i};
            start_edge_q <= start_sync_q[1] & ~start_sync_q[2];
        end
    end

    always_comb begin
        state_d    = state_q;
        init_cmd_o = ddr3_dfi_pkg::DFI_NOP;
        case (state_q)
            S_IDLE: begin
                init_cmd_o = ddr3_dfi_pkg::DFI_IDLE;
                if (start_edge_q) state_d = S_RESET;
            end
            S_RESET: begin
                init_cmd_o.reset_n = 1'b0;
                init_cmd_o.cke     = 1'b0;
                if (timer_q >= ddr3_timing_pkg::T_RESET) state_d = S_CKE_LOW;
            end
            S_CKE_LOW: begin
                init_cmd_o.cke = 1'b0;  // Reset released, clock still gated
                if (timer_q >= ddr3_timing_pkg::T_STABLE) state_d = S_STABLE;
            end
            S_STABLE: begin
                if (timer_q >= ddr3_timing_pkg::T_INIT_WAIT) state_d = S_MRS2;
            end
            S_MRS2: begin
                init_cmd_o = mrs_cmd(ddr3_dfi_pkg::BANK_MR2, ddr3_dfi_pkg::MR2_VAL);
                if (timer_q >= ddr3_timing_pkg::T_MRD) state_d = S_MRS3;
            end
            S_MRS3: begin
                init_cmd_o = mrs_cmd(ddr3_dfi_pkg::BANK_MR3, ddr3_dfi_pkg::MR3_VAL);
                if (timer_q >= ddr3_timing_pkg::T_MRD) state_d = S_MRS1;
            end
            S_MRS1: begin
                init_cmd_o = mrs_cmd(ddr3_dfi_pkg::BANK_MR1, ddr3_dfi_pkg::MR1_VAL);
                if (timer_q >= ddr3_timing_pkg::T_MRD) state_d = S_MRS0;
            end
            S_MRS0: begin
                init_cmd_o = mrs_cmd(ddr3_dfi_pkg::BANK_MR0, ddr3_dfi_pkg::MR0_VAL);
                if (timer_q >= ddr3_timing_pkg::T_MRD) state_d = S_ZQCL;
            end
            S_ZQCL: begin
                init_cmd_o.we_n                           = 1'b0;
                init_cmd_o.address[ddr3_dfi_pkg::A10_BIT] = 1'b1;  // Long calibration
                if (timer_q >= ddr3_timing_pkg::T_ZQINIT) state_d = S_SETTLE;
            end
            S_SETTLE: begin
                // DLL lock and calibration settle
                if (timer_q >= ddr3_timing_pkg::T_INIT_WAIT) state_d = S_HANDOFF;
            end
            S_HANDOFF: begin
                if (test_done_i) state_d = S_DONE;
            end
            S_DONE: begin
                if (start_edge_q) state_d = S_IDLE;  // Rearm for the next run
            end
            default: state_d = S_IDLE;
        endcase
    end

    assign settle_end = (state_q == S_SETTLE) && (state_d == S_HANDOFF);

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            state_q     <= S_IDLE;
            timer_q     <= '0;
            init_done_q <= 1'b0;
            test_go_q   <= 1'b0;
            active_q    <= 1'b0;
        end else begin
            state_q   <= state_d;
            timer_q   <= (state_d != state_q) ? '0 : timer_q + 1'b1;
            test_go_q <= settle_end;
            if (settle_end) begin
                init_done_q <= 1'b1;
            end else if (state_d == S_IDLE) begin
                init_done_q <= 1'b0;
            end
            if (state_q == S_IDLE && start_edge_q) begin
                active_q <= 1'b1;
            end else if (test_done_i) begin
                active_q <= 1'b0;
            end
        end
    end

    assign init_done_o = init_done_q;
    assign test_go_o   = test_go_q;
    assign active_o    = active_q;

endmodule : ddr3_init_seq

`default_nettype wire

// ==== ddr3_dfi_pkg.sv ====
// DDR3 DFI command bus
// One-cycle command word, idle values, mode-register settings and the read result
`default_nettype none

package ddr3_dfi_pkg;

    typedef struct packed {
        logic        cs_n;
        logic        ras_n;
        logic        cas_n;
        logic        we_n;
        logic        cke;
        logic        reset_n;
        logic        odt;
        logic [14:0] address;
        logic [2:0]  bank;
        logic        wrdata_en;
        logic [31:0] wrdata;
        logic [3:0]  wrdata_mask;
        logic        rddata_en;
    } dfi_cmd_t;

    // Chip selected, clock enabled, no command
    localparam dfi_cmd_t DFI_NOP = '{cs_n: 1'b0, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
                                     cke: 1'b1, reset_n: 1'b1, odt: 1'b0,
                                     address: 15'd0, bank: 3'd0, wrdata_en: 1'b0,
                                     wrdata: 32'd0, wrdata_mask: 4'h0, rddata_en: 1'b0};

    // Deselected with CKE low, used before power-up and out of reset
    localparam dfi_cmd_t DFI_IDLE = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
                                      cke: 1'b0, reset_n: 1'b1, odt: 1'b0,
                                      address: 15'd0, bank: 3'd0, wrdata_en: 1'b0,
                                      wrdata: 32'd0, wrdata_mask: 4'h0, rddata_en: 1'b0};

    localparam logic [14:0] MR0_VAL = 15'h0520;  // WR 6, DLL reset, CL 6, BL 8
    localparam logic [14:0] MR1_VAL = 15'h0000;  // DLL enable, RZQ/6 drive
    localparam logic [14:0] MR2_VAL = 15'h0000;
    localparam logic [14:0] MR3_VAL = 15'h0000;

    localparam logic [2:0] BANK_MR0 = 3'b000;
    localparam logic [2:0] BANK_MR1 = 3'b001;
    localparam logic [2:0] BANK_MR2 = 3'b010;
    localparam logic [2:0] BANK_MR3 = 3'b011;

    localparam int A10_BIT = 10;  // Precharge all / ZQ long

    typedef struct packed {
        logic        valid;
        logic        match;
        logic [31:0] data;
    } rd_result_t;

endpackage : ddr3_dfi_pkg

`default_nettype wire

// ==== ddr3_timing_pkg.sv ====
// DDR3 decay test timing
// Wait counts in clk_phy_sys cycles, plus the pattern and address of the test word
`default_nettype none

package ddr3_timing_pkg;

    localparam int TIMER_W = 24;

    // Power-up sequence
    localparam logic [TIMER_W-1:0] T_RESET     = 24'd40_000;   // Reset low hold
    localparam logic [TIMER_W-1:0] T_STABLE    = 24'd100_000;  // CKE low hold
    localparam logic [TIMER_W-1:0] T_INIT_WAIT = 24'd1024;     // CKE high wait and final settle
    localparam logic [TIMER_W-1:0] T_MRD       = 24'd20;       // tMRD with margin
    localparam logic [TIMER_W-1:0] T_ZQINIT    = 24'd512;

    // Row and column access
    localparam logic [TIMER_W-1:0] T_RCD        = 24'd15;
    localparam logic [TIMER_W-1:0] T_WR         = 24'd15;
    localparam logic [TIMER_W-1:0] T_RP         = 24'd15;
    localparam logic [TIMER_W-1:0] T_RD_TIMEOUT = 24'd15;      // Give up on read data after this

    // Retention period, no refresh is issued
    localparam logic [TIMER_W-1:0] T_DECAY = 24'd200_000;

    // Alternating bits so a decayed cell shows up in either polarity
    localparam logic [31:0] TEST_PATTERN = 32'hA5A5_5A5A;

    // Fixed test location
    localparam logic [13:0] TEST_ROW  = 14'h0000;
    localparam logic [9:0]  TEST_COL  = 10'h000;
    localparam logic [2:0]  TEST_BANK = 3'b000;

endpackage : ddr3_timing_pkg

`default_nettype wire
